// ==== hw/axi_bus_pkg.sv ====
/* AXI widths and response codes shared by the slave controller.
   Imported by the write path, the read path, the FIFO and the top level */
package axi_bus_pkg;

    localparam int DATA_W = 8;              // One byte per beat
    localparam int ADDR_W = 32;
    localparam int ID_W   = 5;              // Master transaction ID
    localparam int LEN_W  = 8;              // Burst carries len+1 beats

    // Only the two codes this slave ever returns
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11                 // Start address outside the map
    } resp_e;

endpackage

// ==== hw/slv_map_pkg.sv ====
/* Memory map of the slave: region bases and the start-address decode.
   The write and read burst engines call map_region on each new request */
package slv_map_pkg;
    import axi_bus_pkg::*;

    localparam logic [ADDR_W-1:0] CONF_BASE  = 32'h2000_0000;  // Byte registers
    localparam logic [ADDR_W-1:0] WR_ST_BASE = 32'h2100_0000;  // Single stream address

    typedef enum logic [1:0] {
        REGION_CONF,
        REGION_WR_ST,
        REGION_NONE
    } region_e;

    // Region of a burst, judged by its start address only
    function automatic region_e map_region(input logic [ADDR_W-1:0] addr,
                                           input int unsigned reg_num);
        region_e region;
        region = REGION_NONE;
        if ((addr >= CONF_BASE) && ((addr - CONF_BASE) < reg_num)) begin
            region = REGION_CONF;
        end else if (addr == WR_ST_BASE) begin
            region = REGION_WR_ST;
        end
        return region;
    endfunction

endpackage

// ==== hw/axi_skid_buf.sv ====
`timescale 1ns/10ps
/* Two-entry valid/ready buffer placed on every AXI channel.
   Ready comes from flops only, so no combinational path crosses it */
module axi_skid_buf #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] in_data_i,
    input  logic             in_valid_i,
    output logic             in_ready_o,
    output logic [WIDTH-1:0] out_data_o,
    output logic             out_valid_o,
    input  logic             out_ready_i
);
    logic [WIDTH-1:0] mem [0:1];    // Two slots, used as a tiny ring
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       cnt;          // 0, 1 or 2 items held
    logic             push;
    logic             pop;

    assign in_ready_o  = (cnt != 2'd2);    // Drops only when both slots hold data
    assign out_valid_o = (cnt != 2'd0);
    assign out_data_o  = mem[rd_ptr];      // Oldest item

    assign push = in_valid_i & in_ready_o;
    assign pop  = out_valid_o & out_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            cnt    <= 2'd0;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop)  rd_ptr <= ~rd_ptr;
            // Simultaneous push and pop keep the level, full rate
            case ({push, pop})
                2'b10:   cnt <= cnt + 2'd1;
                2'b01:   cnt <= cnt - 2'd1;
                default: cnt <= cnt;
            endcase
        end
    end

    // Slot storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

endmodule

// ==== hw/axi_wr_path.sv ====
`timescale 1ns/10ps
/* Write burst engine. Takes one AW, steers each W beat to a register or the
   stream FIFO, then holds the B response until the B buffer accepts it */
module axi_wr_path
    import axi_bus_pkg::*;
    import slv_map_pkg::*;
#(
    parameter int CONF_REG_NUM = 13
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // AW channel
    input  logic [ID_W-1:0]                 aw_id_i,
    input  logic [ADDR_W-1:0]               aw_addr_i,
    input  logic                            aw_valid_i,
    output logic                            aw_ready_o,
    // W channel
    input  logic [DATA_W-1:0]               w_data_i,
    input  logic                            w_last_i,
    input  logic                            w_valid_i,
    output logic                            w_ready_o,
    // B channel
    output logic [ID_W-1:0]                 b_id_o,
    output resp_e                           b_resp_o,
    output logic                            b_valid_o,
    input  logic                            b_ready_i,
    // Register file write port
    output logic                            reg_we_o,
    output logic [$clog2(CONF_REG_NUM)-1:0] reg_idx_o,
    output logic [DATA_W-1:0]               reg_wdata_o,
    // Stream FIFO push side
    output logic                            fifo_push_o,
    input  logic                            fifo_ready_i
);
    localparam int IDX_W = $clog2(CONF_REG_NUM);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_BURST,
        WR_RESP
    } wr_state_e;

    wr_state_e        state_q;
    region_e          region_q;     // Region of the burst start
    logic [LEN_W-1:0] beat_q;
    logic [ID_W-1:0]  id_q;
    logic [IDX_W-1:0] offset_q;     // First register of the burst
    logic [LEN_W:0]   cur_idx;      // One bit wider, catches overrun
    logic             idx_hit;
    logic             aw_fire;
    logic             w_fire;

    assign aw_ready_o = (state_q == WR_IDLE);    // Next AW only once B is gone
    assign aw_fire    = aw_valid_i & aw_ready_o;

    // Stream beats wait for FIFO room, other regions never stall
    assign w_ready_o = (state_q == WR_BURST) & ((region_q != REGION_WR_ST) | fifo_ready_i);
    assign w_fire    = w_valid_i & w_ready_o;

    assign cur_idx = offset_q + beat_q;
    assign idx_hit = (cur_idx < CONF_REG_NUM);   // Beats past the last register are dropped

    assign reg_we_o    = w_fire & (region_q == REGION_CONF) & idx_hit;
    assign reg_idx_o   = cur_idx[IDX_W-1:0];
    assign reg_wdata_o = w_data_i;
    assign fifo_push_o = (state_q == WR_BURST) & (region_q == REGION_WR_ST) & w_valid_i;

    assign b_valid_o = (state_q == WR_RESP);
    assign b_id_o    = id_q;
    assign b_resp_o  = (region_q == REGION_NONE) ? RESP_DECERR : RESP_OKAY;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= WR_IDLE;
            region_q <= REGION_NONE;
            beat_q   <= '0;
        end else begin
            case (state_q)
                WR_IDLE: if (aw_fire) begin
                    region_q <= map_region(aw_addr_i, CONF_REG_NUM);
                    beat_q   <= '0;
                    state_q  <= WR_BURST;
                end
                WR_BURST: if (w_fire) begin
                    beat_q <= beat_q + 1'b1;
                    if (w_last_i) state_q <= WR_RESP;  // Burst end from the W flag
                end
                WR_RESP: if (b_ready_i) begin
                    state_q <= WR_IDLE;
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    // Request fields, only meaningful after an AW
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            id_q     <= aw_id_i;
            offset_q <= IDX_W'(aw_addr_i - CONF_BASE);
        end
    end

endmodule

// ==== hw/axi_rd_path.sv ====
`timescale 1ns/10ps
/* Read burst engine. Takes one AR and returns len+1 R beats, each a register
   byte, the stream FIFO level, or zero for an unmapped start */
module axi_rd_path
    import axi_bus_pkg::*;
    import slv_map_pkg::*;
#(
    parameter int CONF_REG_NUM = 13
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // AR channel
    input  logic [ID_W-1:0]                 ar_id_i,
    input  logic [ADDR_W-1:0]               ar_addr_i,
    input  logic [LEN_W-1:0]                ar_len_i,
    input  logic                            ar_valid_i,
    output logic                            ar_ready_o,
    // R channel
    output logic [ID_W-1:0]                 r_id_o,
    output logic [DATA_W-1:0]               r_data_o,
    output resp_e                           r_resp_o,
    output logic                            r_last_o,
    output logic                            r_valid_o,
    input  logic                            r_ready_i,
    // Register file read port
    output logic [$clog2(CONF_REG_NUM)-1:0] reg_idx_o,
    input  logic [DATA_W-1:0]               reg_rdata_i,
    // Stream FIFO level
    input  logic [DATA_W-1:0]               fifo_count_i
);
    localparam int IDX_W = $clog2(CONF_REG_NUM);

    typedef enum logic {
        RD_IDLE,
        RD_BURST
    } rd_state_e;

    rd_state_e        state_q;
    region_e          region_q;
    logic [LEN_W-1:0] beat_q;
    logic [LEN_W-1:0] len_q;
    logic [ID_W-1:0]  id_q;
    logic [IDX_W-1:0] offset_q;
    logic [LEN_W:0]   cur_idx;
    logic             idx_hit;
    logic             ar_fire;
    logic             r_fire;

    assign ar_ready_o = (state_q == RD_IDLE);
    assign ar_fire    = ar_valid_i & ar_ready_o;

    assign r_valid_o = (state_q == RD_BURST);    // One beat per cycle while R buffer has room
    assign r_fire    = r_valid_o & r_ready_i;
    assign r_id_o    = id_q;
    assign r_last_o  = (beat_q == len_q);
    assign r_resp_o  = (region_q == REGION_NONE) ? RESP_DECERR : RESP_OKAY;

    assign cur_idx   = offset_q + beat_q;
    assign idx_hit   = (cur_idx < CONF_REG_NUM);
    assign reg_idx_o = cur_idx[IDX_W-1:0];

    always_comb begin
        case (region_q)
            REGION_CONF:  r_data_o = idx_hit ? reg_rdata_i : '0;  // Zero past last reg
            REGION_WR_ST: r_data_o = fifo_count_i;                // Live FIFO level
            default:      r_data_o = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= RD_IDLE;
            region_q <= REGION_NONE;
            beat_q   <= '0;
        end else if (state_q == RD_IDLE) begin
            if (ar_fire) begin
                region_q <= map_region(ar_addr_i, CONF_REG_NUM);
                beat_q   <= '0;
                state_q  <= RD_BURST;
            end
        end else if (r_fire) begin
            beat_q <= beat_q + 1'b1;
            if (r_last_o) state_q <= RD_IDLE;    // AR taken again after beat len
        end
    end

    // Request fields
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            id_q     <= ar_id_i;
            len_q    <= ar_len_i;
            offset_q <= IDX_W'(ar_addr_i - CONF_BASE);
        end
    end

endmodule

// ==== hw/conf_reg_file.sv ====
`timescale 1ns/10ps
/* Byte-wide configuration registers. One write port, one combinational read
   port, and all registers driven out flat with register 0 in the low byte */
module conf_reg_file
    import axi_bus_pkg::*;
#(
    parameter int CONF_REG_NUM = 13
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            we_i,
    input  logic [$clog2(CONF_REG_NUM)-1:0] wr_idx_i,
    input  logic [DATA_W-1:0]               wr_data_i,
    input  logic [$clog2(CONF_REG_NUM)-1:0] rd_idx_i,
    output logic [DATA_W-1:0]               rd_data_o,
    output logic [DATA_W*CONF_REG_NUM-1:0]  conf_reg_o
);
    logic [DATA_W-1:0] regs [0:CONF_REG_NUM-1];

    // Unused codes above the last register read as zero
    assign rd_data_o = (rd_idx_i < CONF_REG_NUM) ? regs[rd_idx_i] : '0;

    for (genvar i = 0; i < CONF_REG_NUM; i++) begin : g_reg
        assign conf_reg_o[i*DATA_W +: DATA_W] = regs[i];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                regs[i] <= '0;    // Chip sees all-zero config after reset
            end else if (we_i && (wr_idx_i == i)) begin
                regs[i] <= wr_data_i;
            end
        end
    end

endmodule

// ==== hw/stream_fifo.sv ====
`timescale 1ns/10ps
/* Write-stream FIFO. The write path pushes W beats in, the chip pops them
   through the stream port, and the level is readable over AXI */
module stream_fifo
    import axi_bus_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push_i,
    output logic              push_ready_o,
    input  logic [DATA_W-1:0] push_data_i,
    output logic [DATA_W-1:0] pop_data_o,
    output logic              pop_valid_o,
    input  logic              pop_ready_i,
    output logic [DATA_W-1:0] count_o
);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);    // Holds 0 to FIFO_DEPTH

    logic [DATA_W-1:0] mem [0:FIFO_DEPTH-1];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  cnt;
    logic              do_push;
    logic              do_pop;

    assign push_ready_o = (cnt != FIFO_DEPTH);    // Refuse when full
    assign pop_valid_o  = (cnt != 0);
    assign pop_data_o   = mem[rd_ptr];            // Oldest entry
    assign count_o      = DATA_W'(cnt);

    assign do_push = push_i & push_ready_o;
    assign do_pop  = pop_valid_o & pop_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            // Pointers wrap at the depth, not at a power of two
            if (do_push) wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)      cnt <= cnt + 1'b1;
            else if (do_pop && !do_push) cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

endmodule

// ==== hw/axi_stream_ctrl.sv ====
`timescale 1ns/10ps
/* AXI4 slave with byte config registers and one write-stream FIFO.
   Every AXI channel passes through a skid buffer before the burst engines */
module axi_stream_ctrl
    import axi_bus_pkg::*;
#(
    parameter int CONF_REG_NUM = 13,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    // AW
    input  logic [ID_W-1:0]                m_awid_i,
    input  logic [ADDR_W-1:0]              m_awaddr_i,
    input  logic                           m_awvalid_i,
    output logic                           m_awready_o,
    // W
    input  logic [DATA_W-1:0]              m_wdata_i,
    input  logic                           m_wlast_i,
    input  logic                           m_wvalid_i,
    output logic                           m_wready_o,
    // B
    output logic [ID_W-1:0]                m_bid_o,
    output logic [1:0]                     m_bresp_o,
    output logic                           m_bvalid_o,
    input  logic                           m_bready_i,
    // AR
    input  logic [ID_W-1:0]                m_arid_i,
    input  logic [ADDR_W-1:0]              m_araddr_i,
    input  logic [LEN_W-1:0]               m_arlen_i,
    input  logic                           m_arvalid_i,
    output logic                           m_arready_o,
    // R
    output logic [ID_W-1:0]                m_rid_o,
    output logic [DATA_W-1:0]              m_rdata_o,
    output logic [1:0]                     m_rresp_o,
    output logic                           m_rlast_o,
    output logic                           m_rvalid_o,
    input  logic                           m_rready_i,
    // To the rest of the chip
    output logic [DATA_W*CONF_REG_NUM-1:0] conf_reg_o,
    output logic [DATA_W-1:0]              wr_st_data_o,
    output logic                           wr_st_valid_o,
    input  logic                           wr_st_ready_i
);
    localparam int IDX_W = $clog2(CONF_REG_NUM);

    // Core side of the buffers
    logic [ID_W-1:0]   aw_id;
    logic [ADDR_W-1:0] aw_addr;
    logic              aw_valid, aw_ready;
    logic [DATA_W-1:0] w_data;
    logic              w_last, w_valid, w_ready;
    logic [ID_W-1:0]   b_id;
    resp_e             b_resp;
    logic              b_valid, b_ready;
    logic [ID_W-1:0]   ar_id;
    logic [ADDR_W-1:0] ar_addr;
    logic [LEN_W-1:0]  ar_len;
    logic              ar_valid, ar_ready;
    logic [ID_W-1:0]   r_id;
    logic [DATA_W-1:0] r_data;
    resp_e             r_resp;
    logic              r_last, r_valid, r_ready;
    // Register file and FIFO hookup
    logic              reg_we;
    logic [IDX_W-1:0]  reg_wr_idx, reg_rd_idx;
    logic [DATA_W-1:0] reg_wdata, reg_rdata;
    logic              fifo_push, fifo_ready;
    logic [DATA_W-1:0] fifo_count;

    axi_skid_buf #(.WIDTH(ID_W + ADDR_W)) aw_buf (
        .clk(clk), .rst_n(rst_n),
        .in_data_i({m_awid_i, m_awaddr_i}), .in_valid_i(m_awvalid_i), .in_ready_o(m_awready_o),
        .out_data_o({aw_id, aw_addr}), .out_valid_o(aw_valid), .out_ready_i(aw_ready)
    );

    axi_skid_buf #(.WIDTH(DATA_W + 1)) w_buf (
        .clk(clk), .rst_n(rst_n),
        .in_data_i({m_wdata_i, m_wlast_i}), .in_valid_i(m_wvalid_i), .in_ready_o(m_wready_o),
        .out_data_o({w_data, w_last}), .out_valid_o(w_valid), .out_ready_i(w_ready)
    );

    axi_skid_buf #(.WIDTH(ID_W + 2)) b_buf (
        .clk(clk), .rst_n(rst_n),
        .in_data_i({b_id, b_resp}), .in_valid_i(b_valid), .in_ready_o(b_ready),
        .out_data_o({m_bid_o, m_bresp_o}), .out_valid_o(m_bvalid_o), .out_ready_i(m_bready_i)
    );

    axi_skid_buf #(.WIDTH(ID_W + LEN_W + ADDR_W)) ar_buf (
        .clk(clk), .rst_n(rst_n),
        .in_data_i({m_arid_i, m_arlen_i, m_araddr_i}), .in_valid_i(m_arvalid_i),
        .in_ready_o(m_arready_o),
        .out_data_o({ar_id, ar_len, ar_addr}), .out_valid_o(ar_valid), .out_ready_i(ar_ready)
    );

    // Payload order id, data, resp, last
    axi_skid_buf #(.WIDTH(ID_W + DATA_W + 3)) r_buf (
        .clk(clk), .rst_n(rst_n),
        .in_data_i({r_id, r_data, r_resp, r_last}), .in_valid_i(r_valid), .in_ready_o(r_ready),
        .out_data_o({m_rid_o, m_rdata_o, m_rresp_o, m_rlast_o}), .out_valid_o(m_rvalid_o),
        .out_ready_i(m_rready_i)
    );

    axi_wr_path #(.CONF_REG_NUM(CONF_REG_NUM)) i_wr_path (
        .clk(clk), .rst_n(rst_n),
        .aw_id_i(aw_id), .aw_addr_i(aw_addr), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
        .w_data_i(w_data), .w_last_i(w_last), .w_valid_i(w_valid), .w_ready_o(w_ready),
        .b_id_o(b_id), .b_resp_o(b_resp), .b_valid_o(b_valid), .b_ready_i(b_ready),
        .reg_we_o(reg_we), .reg_idx_o(reg_wr_idx), .reg_wdata_o(reg_wdata),
        .fifo_push_o(fifo_push), .fifo_ready_i(fifo_ready)
    );

    axi_rd_path #(.CONF_REG_NUM(CONF_REG_NUM)) i_rd_path (
        .clk(clk), .rst_n(rst_n),
        .ar_id_i(ar_id), .ar_addr_i(ar_addr), .ar_len_i(ar_len),
        .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
        .r_id_o(r_id), .r_data_o(r_data), .r_resp_o(r_resp), .r_last_o(r_last),
        .r_valid_o(r_valid), .r_ready_i(r_ready),
        .reg_idx_o(reg_rd_idx), .reg_rdata_i(reg_rdata), .fifo_count_i(fifo_count)
    );

    conf_reg_file #(.CONF_REG_NUM(CONF_REG_NUM)) i_conf_regs (
        .clk(clk), .rst_n(rst_n),
        .we_i(reg_we), .wr_idx_i(reg_wr_idx), .wr_data_i(reg_wdata),
        .rd_idx_i(reg_rd_idx), .rd_data_o(reg_rdata), .conf_reg_o(conf_reg_o)
    );

    // W beat data goes straight in, the write path only gates the push
    stream_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_wr_st_fifo (
        .clk(clk), .rst_n(rst_n),
        .push_i(fifo_push), .push_ready_o(fifo_ready), .push_data_i(w_data),
        .pop_data_o(wr_st_data_o), .pop_valid_o(wr_st_valid_o), .pop_ready_i(wr_st_ready_i),
        .count_o(fifo_count)
    );

endmodule

// ==== sim/tb_axi_tasks.svh ====
/* Bus tasks for the AXI slave testbench: AW/AR/W drivers, B/R collectors,
   stream capture wait and the LCG. Included inside the testbench module */
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

logic [31:0]     lcg_state = 32'd10182;
logic [7:0]      rd_data_q[$];      // Collected R beats
logic [1:0]      rd_resp_q[$];
logic            rd_last_q[$];
logic [ID_W-1:0] rd_id_q[$];

function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];        // Upper bits, low ones repeat quickly
endfunction

// Let n clocks pass, ending 2 ns after an edge
task automatic idle_cycles(input int n);
    repeat (n) begin
        @(posedge clk);
        #2;
    end
endtask

task automatic send_aw(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr);
    int n;
    m_awid_i    = id;
    m_awaddr_i  = addr;
    m_awvalid_i = 1'b1;
    n = 0;
    do begin
        @(posedge clk);
        if (++n > TIMEOUT_CYC) report_hang("AW handshake");
    end while (!m_awready_o);
    #2;
    m_awvalid_i = 1'b0;
endtask

task automatic send_ar(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                       input logic [LEN_W-1:0] len);
    int n;
    m_arid_i    = id;
    m_araddr_i  = addr;
    m_arlen_i   = len;
    m_arvalid_i = 1'b1;
    n = 0;
    do begin
        @(posedge clk);
        if (++n > TIMEOUT_CYC) report_hang("AR handshake");
    end while (!m_arready_o);
    #2;
    m_arvalid_i = 1'b0;
endtask

// Back-to-back beats, last flag on the final one
task automatic send_w_burst(input logic [7:0] data[$]);
    int n;
    foreach (data[i]) begin
        m_wdata_i  = data[i];
        m_wlast_i  = (i == data.size() - 1);
        m_wvalid_i = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            if (++n > TIMEOUT_CYC) report_hang("W handshake");
        end while (!m_wready_o);
        #2;
    end
    m_wvalid_i = 1'b0;
    m_wlast_i  = 1'b0;
endtask

// Ready stays low between responses, optionally for a random span first
task automatic collect_b(input bit stall, output logic [ID_W-1:0] id,
                         output logic [1:0] resp);
    int n;
    if (stall) idle_cycles(int'(rand_byte() % 8'd6));
    m_bready_i = 1'b1;
    n = 0;
    do begin
        @(posedge clk);
        if (++n > TIMEOUT_CYC) report_hang("B response");
    end while (!m_bvalid_o);
    id   = m_bid_o;
    resp = m_bresp_o;
    #2;
    m_bready_i = 1'b0;
endtask

task automatic collect_r(input int beats, input bit stall);
    int n;
    for (int i = 0; i < beats; i++) begin
        if (stall) idle_cycles(int'(rand_byte() % 8'd6));
        m_rready_i = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            if (++n > TIMEOUT_CYC) report_hang("R beat");
        end while (!m_rvalid_o);
        rd_data_q.push_back(m_rdata_o);
        rd_resp_q.push_back(m_rresp_o);
        rd_last_q.push_back(m_rlast_o);
        rd_id_q.push_back(m_rid_o);
        #2;
        m_rready_i = 1'b0;
    end
endtask

task automatic wait_stream(input int count);
    int n;
    n = 0;
    while (stream_q.size() < count) begin
        idle_cycles(1);
        if (++n > TIMEOUT_CYC) report_hang("stream bytes on wr_st_data_o");
    end
endtask

`endif

// ==== sim/tb_axi_stream_ctrl.sv ====
`timescale 1ns/10ps
/* Testbench for the AXI slave controller. Drives config, stream and unmapped
   bursts and checks responses against a byte model of the registers */
module tb_axi_stream_ctrl
    import axi_bus_pkg::*;
    import slv_map_pkg::*;
();
    localparam int CONF_REG_NUM = 13;
    localparam int FIFO_DEPTH   = 4;
    localparam int TIMEOUT_CYC  = 200;    // Per wait loop

    logic clk, rst_n;
    logic [ID_W-1:0] m_awid_i, m_bid_o, m_arid_i, m_rid_o;
    logic [ADDR_W-1:0] m_awaddr_i, m_araddr_i;
    logic m_awvalid_i, m_awready_o, m_wlast_i, m_wvalid_i, m_wready_o;
    logic [DATA_W-1:0] m_wdata_i, m_rdata_o, wr_st_data_o;
    logic [1:0] m_bresp_o, m_rresp_o;
    logic m_bvalid_o, m_bready_i, m_arvalid_i, m_arready_o;
    logic [LEN_W-1:0] m_arlen_i;
    logic m_rlast_o, m_rvalid_o, m_rready_i, wr_st_valid_o, wr_st_ready_i;
    logic [DATA_W*CONF_REG_NUM-1:0] conf_reg_o;
    logic [7:0] exp_conf [0:CONF_REG_NUM-1];    // Register model
    logic [7:0] stream_q[$];                    // Bytes seen on the stream port
    logic [7:0] beats[$], exp_rd[$];
    logic [ID_W-1:0] id, bid;
    logic [1:0] bresp;

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_hang(input string what);
        $display("Timeout: no %s within %0d clock cycles", what, TIMEOUT_CYC);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    `include "tb_axi_tasks.svh"

    axi_stream_ctrl #(.CONF_REG_NUM(CONF_REG_NUM), .FIFO_DEPTH(FIFO_DEPTH))
        i_axi_stream_ctrl (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (wr_st_valid_o && wr_st_ready_i) stream_q.push_back(wr_st_data_o);
    end

    // Output valid must hold with its payload until taken
    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_bvalid_o && !m_bready_i |=> m_bvalid_o && $stable({m_bid_o, m_bresp_o}))
        else report_error("B valid or payload changed before ready");
    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_rvalid_o && !m_rready_i |=> m_rvalid_o
            && $stable({m_rid_o, m_rdata_o, m_rresp_o, m_rlast_o}))
        else report_error("R valid or payload changed before ready");
    a_st_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_st_valid_o && !wr_st_ready_i |=> wr_st_valid_o && $stable(wr_st_data_o))
        else report_error("Stream valid or data changed before ready");

    task automatic check_conf();
        for (int i = 0; i < CONF_REG_NUM; i++) begin
            assert (conf_reg_o[i*8 +: 8] == exp_conf[i])
                else report_error($sformatf("conf_reg_o byte %0d is %02h, expected %02h",
                                            i, conf_reg_o[i*8 +: 8], exp_conf[i]));
        end
    endtask

    // Model updates only for a config start and skips bytes past the last register
    task automatic write_burst(input logic [ADDR_W-1:0] addr, input logic [7:0] data[$],
                               input logic [1:0] exp_resp, input bit stall);
        logic [ID_W-1:0] wid;
        wid = ID_W'(rand_byte());
        send_aw(wid, addr);
        send_w_burst(data);
        if (addr >= CONF_BASE && addr - CONF_BASE < CONF_REG_NUM) begin
            foreach (data[i]) begin
                if (addr - CONF_BASE + i < CONF_REG_NUM) begin
                    exp_conf[addr - CONF_BASE + i] = data[i];
                end
            end
        end
        collect_b(stall, bid, bresp);
        assert (bid == wid && bresp == exp_resp)
            else report_error($sformatf("B id/resp %0h/%0d, expected %0h/%0d",
                                        bid, bresp, wid, exp_resp));
        check_conf();
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [7:0] exp[$],
                              input logic [1:0] exp_resp, input bit stall);
        logic [ID_W-1:0] rid;
        rid = ID_W'(rand_byte());
        rd_data_q.delete();
        rd_resp_q.delete();
        rd_last_q.delete();
        rd_id_q.delete();
        send_ar(rid, addr, LEN_W'(exp.size() - 1));
        collect_r(exp.size(), stall);
        foreach (exp[i]) begin
            assert (rd_data_q[i] == exp[i] && rd_resp_q[i] == exp_resp && rd_id_q[i] == rid
                    && rd_last_q[i] == (i == exp.size() - 1))
                else report_error($sformatf("R beat %0d: data %02h resp %0d id %0h last %0b",
                                            i, rd_data_q[i], rd_resp_q[i], rd_id_q[i],
                                            rd_last_q[i]));
        end
    endtask

    task automatic conf_expect(input int offset, input int n);
        exp_rd.delete();
        for (int i = 0; i < n; i++) begin
            exp_rd.push_back(offset + i < CONF_REG_NUM ? exp_conf[offset + i] : 8'h00);
        end
    endtask

    task automatic check_stream(input logic [7:0] data[$]);
        wait_stream(data.size());
        foreach (data[i]) begin
            assert (stream_q[i] == data[i])
                else report_error($sformatf("Stream byte %0d is %02h, expected %02h",
                                            i, stream_q[i], data[i]));
        end
        stream_q.delete();
    endtask

    initial begin
        {m_awid_i, m_awaddr_i, m_awvalid_i, m_wdata_i, m_wlast_i, m_wvalid_i} = '0;
        {m_arid_i, m_araddr_i, m_arlen_i, m_arvalid_i} = '0;
        {m_bready_i, m_rready_i, wr_st_ready_i} = '0;    // Responses held until collected
        foreach (exp_conf[i]) exp_conf[i] = 8'h00;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;
        assert (!m_bvalid_o && !m_rvalid_o && !wr_st_valid_o && conf_reg_o == '0)
            else report_error("Outputs not idle after reset");
        assert (m_awready_o && m_wready_o && m_arready_o)
            else report_error("Request channels not ready after reset");

        // Config round trip at offset 3
        beats.delete();
        repeat (4) beats.push_back(rand_byte());
        write_burst(CONF_BASE + 3, beats, RESP_OKAY, 1'b0);
        conf_expect(3, 4);
        read_check(CONF_BASE + 3, exp_rd, RESP_OKAY, 1'b0);

        // Stream write with stalled consumer, level readback, drain
        beats.delete();
        repeat (3) beats.push_back(rand_byte());
        write_burst(WR_ST_BASE, beats, RESP_OKAY, 1'b0);
        exp_rd = {8'd3};
        read_check(WR_ST_BASE, exp_rd, RESP_OKAY, 1'b0);
        wr_st_ready_i = 1'b1;
        check_stream(beats);
        wr_st_ready_i = 1'b0;

        // Seven beats into a four-deep FIFO so W backs up
        beats.delete();
        repeat (7) beats.push_back(rand_byte());
        id = ID_W'(rand_byte());
        send_aw(id, WR_ST_BASE);
        fork
            send_w_burst(beats);
        join_none
        repeat (20) begin
            idle_cycles(1);
            assert (!m_bvalid_o) else report_error("B arrived while the stream was stalled");
        end
        assert (!m_wready_o) else report_error("W still ready with the FIFO full");
        wr_st_ready_i = 1'b1;
        check_stream(beats);
        collect_b(1'b0, bid, bresp);
        assert (bid == id && bresp == RESP_OKAY)
            else report_error($sformatf("Stream B id/resp %0h/%0d", bid, bresp));
        wr_st_ready_i = 1'b0;

        // Unmapped start address, register model stays as it was
        beats = {rand_byte(), rand_byte()};
        write_burst(32'h3000_0000, beats, RESP_DECERR, 1'b0);
        exp_rd = {8'h00, 8'h00};
        read_check(32'h3000_0000, exp_rd, RESP_DECERR, 1'b0);

        // Stalled B and R with a burst running past the last register
        beats.delete();
        repeat (6) beats.push_back(rand_byte());
        write_burst(CONF_BASE + 8, beats, RESP_OKAY, 1'b1);
        conf_expect(8, 6);
        read_check(CONF_BASE + 8, exp_rd, RESP_OKAY, 1'b1);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+sim
hw/axi_bus_pkg.sv
hw/slv_map_pkg.sv
hw/axi_skid_buf.sv
hw/axi_wr_path.sv
hw/axi_rd_path.sv
hw/conf_reg_file.sv
hw/stream_fifo.sv
hw/axi_stream_ctrl.sv
sim/tb_axi_stream_ctrl.sv
